//--- hdl/arb_macros.svh
`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

// requesters seen by the tree
`define ARB_NUM_REQ 16

// first level split
`define ARB_GROUP_NUM 4
`define ARB_GROUP_WIDTH (`ARB_NUM_REQ / `ARB_GROUP_NUM)

// group number in the upper bits, member in the lower bits
`define ARB_IDX_W 4

`endif

//--- hdl/arb_pkg.sv
`include "arb_macros.svh"

package arb_pkg;

    // one bit per requester, requester 0 in bit 0
    typedef logic [`ARB_NUM_REQ-1:0] req_vec_t;

    // one bit per group
    typedef logic [`ARB_GROUP_NUM-1:0] grp_vec_t;

    // local one-hot grants, group 0 in the low slice
    typedef logic [`ARB_GROUP_NUM-1:0][`ARB_GROUP_WIDTH-1:0] grp_grant_t;

    // grant as seen by the consumer
    // onehot and index are only meaningful while valid is high
    typedef struct packed {
        logic                  valid;
        logic [`ARB_IDX_W-1:0] index;
        req_vec_t              onehot;
    } grant_s;

endpackage

//--- hdl/thermo_rr_arbiter.sv
`timescale 1ns/1ns

module thermo_rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] request,
    input  logic             advance,
    output logic [WIDTH-1:0] grant,
    output logic             any_request
);

    // ones above the last accepted grant
    logic [WIDTH-1:0] prio_mask;
    logic [WIDTH-1:0] masked_request;
    logic [WIDTH-1:0] thermo_all;
    logic [WIDTH-1:0] thermo_masked;
    logic [WIDTH-1:0] thermo_sel;
    logic [WIDTH-1:0] edge_mask;

    // bit i set when any input bit at or below i is set
    function automatic logic [WIDTH-1:0] thermo(input logic [WIDTH-1:0] vec);
        logic [WIDTH-1:0] code;
        code[0] = vec[0];
        for (int i = 1; i < WIDTH; i++) begin
            code[i] = code[i-1] | vec[i];
        end
        return code;
    endfunction

    assign masked_request = request & prio_mask;
    assign thermo_all     = thermo(request);
    assign thermo_masked  = thermo(masked_request);

    // nobody above the pointer, so wrap to the lowest requester
    assign thermo_sel = thermo_masked[WIDTH-1] ? thermo_masked : thermo_all;

    // the rising edge of the code is the winner
    assign edge_mask   = {thermo_sel[WIDTH-2:0], 1'b0};
    assign grant       = thermo_sel ^ edge_mask;
    assign any_request = thermo_all[WIDTH-1];

    // next search starts just above the winner
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prio_mask <= '1;
        end else if (advance) begin
            prio_mask <= edge_mask;
        end
    end

endmodule

//--- hdl/arb_ctrl.sv
`timescale 1ns/1ns

module arb_ctrl (
    input  logic               ready,
    input  arb_pkg::grp_vec_t  group_any,
    input  arb_pkg::grp_vec_t  top_grant,
    output logic               grant_valid,
    output logic               top_advance,
    output arb_pkg::grp_vec_t  group_advance
);

    // handshake completes this cycle
    logic accept;

    // any requester anywhere gives a winner
    assign grant_valid = |group_any;

    assign accept = grant_valid & ready;

    // top pointer moves on every accepted grant
    assign top_advance = accept;

    // only the winning group rotates
    // losing groups keep their pointer for their next win
    always_comb begin
        group_advance = '0;
        if (accept) begin
            group_advance = top_grant;
        end
    end

endmodule

//--- hdl/grant_combine.sv
`timescale 1ns/1ns
`include "arb_macros.svh"

module grant_combine (
    input  arb_pkg::grp_grant_t     group_grant,
    input  arb_pkg::grp_vec_t       top_grant,
    output arb_pkg::req_vec_t       onehot,
    output logic [`ARB_IDX_W-1:0]   index
);

    localparam int GRP_IDX_W = $clog2(`ARB_GROUP_NUM);
    localparam int LOC_IDX_W = $clog2(`ARB_GROUP_WIDTH);
    // encoder input wide enough for either one-hot vector
    localparam int ENC_W = (`ARB_GROUP_NUM > `ARB_GROUP_WIDTH) ?
                           `ARB_GROUP_NUM : `ARB_GROUP_WIDTH;

    arb_pkg::grp_grant_t          masked_grant;
    logic [`ARB_GROUP_WIDTH-1:0]  local_grant;
    int unsigned                  group_pos;
    int unsigned                  local_pos;

    // or of the set positions is exact for a one-hot input
    function automatic int unsigned onehot_pos(input logic [ENC_W-1:0] vec);
        int unsigned pos;
        pos = 0;
        for (int unsigned i = 0; i < ENC_W; i++) begin
            if (vec[i]) begin
                pos = pos | i;
            end
        end
        return pos;
    endfunction

    // drop groups that lost at the top, fold the rest into one slice
    always_comb begin
        local_grant = '0;
        for (int g = 0; g < `ARB_GROUP_NUM; g++) begin
            masked_grant[g] = top_grant[g] ? group_grant[g] : '0;
            local_grant     = local_grant | masked_grant[g];
        end
    end

    // group slices are already in requester order
    assign onehot = masked_grant;

    assign group_pos = onehot_pos(ENC_W'(top_grant));
    assign local_pos = onehot_pos(ENC_W'(local_grant));

    // group number on top, member position below
    assign index = {GRP_IDX_W'(group_pos), LOC_IDX_W'(local_pos)};

endmodule

//--- hdl/arb_tree_top.sv
`timescale 1ns/1ns
`include "arb_macros.svh"

module arb_tree_top (
    input  logic               clk,
    input  logic               reset,
    input  arb_pkg::req_vec_t  request,
    input  logic               ready,
    output arb_pkg::grant_s    grant
);

    // first level results
    arb_pkg::grp_grant_t          group_grant;
    arb_pkg::grp_vec_t            group_any;
    arb_pkg::grp_vec_t            group_advance;

    // second level results
    arb_pkg::grp_vec_t            top_grant;
    logic                         top_advance;

    logic                         grant_valid;
    arb_pkg::req_vec_t            grant_onehot;
    logic [`ARB_IDX_W-1:0]        grant_index;

    // one local round robin per group of requesters
    for (genvar g = 0; g < `ARB_GROUP_NUM; g++) begin : gen_group
        thermo_rr_arbiter #(
            .WIDTH        (`ARB_GROUP_WIDTH)
        ) u_group_arb (
            .clk          (clk),
            .reset        (reset),
            .request      (request[g*`ARB_GROUP_WIDTH +: `ARB_GROUP_WIDTH]),
            .advance      (group_advance[g]),
            .grant        (group_grant[g]),
            .any_request  (group_any[g])
        );
    end

    // picks among groups that have something pending
    // its own any_request repeats grant_valid and is left open
    thermo_rr_arbiter #(
        .WIDTH        (`ARB_GROUP_NUM)
    ) u_top_arb (
        .clk          (clk),
        .reset        (reset),
        .request      (group_any),
        .advance      (top_advance),
        .grant        (top_grant),
        .any_request  ()
    );

    arb_ctrl u_ctrl (
        .ready          (ready),
        .group_any      (group_any),
        .top_grant      (top_grant),
        .grant_valid    (grant_valid),
        .top_advance    (top_advance),
        .group_advance  (group_advance)
    );

    grant_combine u_combine (
        .group_grant  (group_grant),
        .top_grant    (top_grant),
        .onehot       (grant_onehot),
        .index        (grant_index)
    );

    assign grant = '{
        valid:  grant_valid,
        index:  grant_index,
        onehot: grant_onehot
    };

endmodule

//--- verif/arb_props.sv
`timescale 1ns/1ns

module arb_props (
    input logic              clk,
    input logic              reset,
    input arb_pkg::req_vec_t request,
    input logic              ready,
    input arb_pkg::grant_s   grant
);

    // number of assertion failures so far
    int unsigned assert_errors = 0;

    // at most one winner at a time
    onehot_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant.onehot))
    else begin
        $error("grant vector has more than one bit set: %h", grant.onehot);
        assert_errors++;
    end

    valid_matches_request: assert property (@(posedge clk) disable iff (reset)
        grant.valid == (|request))
    else begin
        $error("grant valid %b does not match request %h", grant.valid, request);
        assert_errors++;
    end

    // a winner must be asking
    grant_is_requested: assert property (@(posedge clk) disable iff (reset)
        (grant.onehot & ~request) == '0)
    else begin
        $error("grant %h given to an idle requester, request %h", grant.onehot, request);
        assert_errors++;
    end

    // back-pressure freezes the pointers
    hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
        !$past(ready) && $stable(request) |-> $stable(grant))
    else begin
        $error("grant changed while ready was low and request was stable");
        assert_errors++;
    end

endmodule

//--- verif/arb_tb.sv
`timescale 1ns/1ns
`include "arb_macros.svh"

module arb_tb;

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 16;
    localparam int    DRIVE_DELAY  = 5;
    localparam int    SAMPLE_DELAY = 80;
    localparam string DATA_FILE    = "verif/arb_testdata.txt";

    // one line of the data file
    typedef struct packed {
        arb_pkg::req_vec_t      request;
        logic                   ready;
        logic                   valid;
        logic [`ARB_IDX_W-1:0]  index;
        logic [15:0]            line_no;
    } vector_s;

    logic              clk = 1'b0;
    logic              reset;
    arb_pkg::req_vec_t request;
    logic              ready;
    arb_pkg::grant_s   grant;

    vector_s     vectors[$];
    bit          vectors_loaded = 1'b0;
    int unsigned check_count    = 0;
    int unsigned mismatch_count = 0;
    int unsigned file_errors    = 0;

    arb_tree_top DUT (
        .clk      (clk),
        .reset    (reset),
        .request  (request),
        .ready    (ready),
        .grant    (grant)
    );

    bind arb_tree_top arb_props u_props (
        .clk      (clk),
        .reset    (reset),
        .request  (request),
        .ready    (ready),
        .grant    (grant)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // blank lines and lines starting with # carry no vector
    function automatic bit skip_line(input string text);
        for (int i = 0; i < text.len(); i++) begin
            if (text[i] == "#") begin
                return 1'b1;
            end
            if (text[i] != " " && text[i] != "\t" && text[i] != "\n" && text[i] != "\r") begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          code;
        int          fields;
        int          line_no;
        string       text;
        int unsigned req_val;
        int unsigned ready_val;
        int unsigned valid_val;
        int unsigned index_val;
        vector_s     vec;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("error: cannot open data file %s", DATA_FILE);
            file_errors++;
            return;
        end
        line_no = 0;
        code = $fgets(text, fd);
        while (code != 0) begin
            line_no++;
            if (!skip_line(text)) begin
                fields = $sscanf(text, "%h %h %h %h", req_val, ready_val, valid_val, index_val);
                if (fields != 4 || req_val > 32'hffff || ready_val > 1 || valid_val > 1 ||
                    index_val >= `ARB_NUM_REQ) begin
                    $display("error: data file line %0d is malformed", line_no);
                    file_errors++;
                end else begin
                    vec.request = arb_pkg::req_vec_t'(req_val);
                    vec.ready   = ready_val[0];
                    vec.valid   = valid_val[0];
                    vec.index   = `ARB_IDX_W'(index_val);
                    vec.line_no = 16'(line_no);
                    vectors.push_back(vec);
                end
            end
            code = $fgets(text, fd);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("error: data file %s holds no vectors", DATA_FILE);
            file_errors++;
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // drive one vector after the edge, sample before the next one
    task automatic run_vector(input vector_s vec);
        arb_pkg::req_vec_t exp_onehot;
        @(posedge clk);
        #(DRIVE_DELAY);
        request = vec.request;
        ready   = vec.ready;
        #(SAMPLE_DELAY);
        // winner bit follows from the expected index
        exp_onehot = '0;
        if (vec.valid) begin
            exp_onehot[vec.index] = 1'b1;
        end
        compare_value($sformatf("line %0d valid", vec.line_no),
                      32'(vec.valid), 32'(grant.valid));
        compare_value($sformatf("line %0d index", vec.line_no),
                      32'(vec.index), 32'(grant.index));
        compare_value($sformatf("line %0d onehot", vec.line_no),
                      32'(exp_onehot), 32'(grant.onehot));
    endtask

    // limit scales with the vector count
    initial begin : watchdog
        longint limit_ns;
        wait (vectors_loaded);
        limit_ns = (longint'(vectors.size()) + RESET_CYCLES + 20) * CLK_PERIOD;
        #(limit_ns);
        $display("error: watchdog expired after %0d ns, the run stalled", limit_ns);
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        int unsigned assert_errors;
        reset   = 1'b1;
        request = '0;
        ready   = 1'b0;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        if (file_errors == 0) begin
            foreach (vectors[i]) begin
                run_vector(vectors[i]);
            end
        end
        @(posedge clk);
        // let the assertions of the last edge settle
        #(DRIVE_DELAY);
        assert_errors = DUT.u_props.assert_errors;
        $display("summary: %0d checks, %0d mismatches, %0d assertion failures, %0d file errors",
                 check_count, mismatch_count, assert_errors, file_errors);
        if (mismatch_count == 0 && assert_errors == 0 && file_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hdl
hdl/arb_pkg.sv
hdl/thermo_rr_arbiter.sv
hdl/arb_ctrl.sv
hdl/grant_combine.sv
hdl/arb_tree_top.sv
verif/arb_props.sv
verif/arb_tb.sv

//--- run.sh
#!/bin/sh
# build the arbiter testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module arb_tb -Mdir obj_dir -f build.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Varb_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the run counts as passed only if the testbench said so
if echo "$sim_out" | grep -qx "All checks passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- verif/arb_testdata.txt
# columns: request (hex, bit n = requester n), ready, expected valid, expected index (hex)
# one vector per clock cycle, applied after reset
# idle, then a single requester
0000 1 0 0
0000 0 0 0
0040 0 1 6
0040 1 1 6
0000 1 0 0
# all sixteen requesting, ready high
ffff 1 1 8
ffff 1 1 c
ffff 1 1 0
ffff 1 1 7
ffff 1 1 9
ffff 1 1 d
ffff 1 1 1
ffff 1 1 4
ffff 1 1 a
ffff 1 1 e
ffff 1 1 2
ffff 1 1 5
ffff 1 1 b
ffff 1 1 f
ffff 1 1 3
ffff 1 1 6
# back-pressure holds the grant
ffff 0 1 8
ffff 0 1 8
ffff 0 1 8
ffff 0 1 8
ffff 1 1 8
ffff 1 1 c
ffff 0 1 0
ffff 0 1 0
ffff 1 1 0
ffff 1 1 7
# losing groups keep their local pointer
0f0f 1 1 9
0f0f 1 1 1
0f0f 1 1 a
0f0f 1 1 2
0f0f 1 1 b
0f0f 1 1 3
f002 1 1 d
f002 1 1 1
f0f0 1 1 4
f0f0 1 1 e
f0f0 1 1 5
# requesters drop out once served, wrap from 15 to 0
c421 1 1 a
c021 1 1 f
4021 0 1 0
4021 1 1 0
4020 1 1 5
4000 1 1 e
0000 1 0 0
8001 1 1 0
8000 1 1 f
0001 1 1 0
0000 0 0 0
# ready toggling under full load
ffff 0 1 6
ffff 1 1 6
ffff 0 1 b
ffff 1 1 b
ffff 0 1 c
ffff 1 1 c
ffff 0 1 1
ffff 1 1 1
ffff 0 1 7
ffff 1 1 7
ffff 0 1 8
ffff 1 1 8
ffff 0 1 d
ffff 1 1 d
ffff 0 1 2
ffff 1 1 2
0000 1 0 0
0000 0 0 0
